/* design/ppu_obj_pkg.sv */
`default_nettype none

package ppu_obj_pkg;

    // Attribute nibble bit positions, upper half of the OAM attr byte
    localparam int ATTR_PRIO  = 3;
    localparam int ATTR_VFLIP = 2;
    localparam int ATTR_HFLIP = 1;
    localparam int ATTR_PAL   = 0;

    // What a slot keeps for one sprite on the current line
    typedef struct packed {
        logic [2:0] row;    // Row inside the 8-line tile
        logic [7:0] tile;   // Tile index, low bit fixed up for 8x16
        logic [3:0] attrs;  // Priority, vflip, hflip, palette
    } sprite_data_t;

    // Even OAM word is {y, x}, odd word is {tile, attrs}
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] x;
        logic [7:0] tile;
        logic [7:0] attrs;
    } oam_entry_t;

    typedef struct packed {
        logic [1:0] color;  // Zero is transparent
        logic       pal;
        logic       prio;
    } obj_pixel_t;

endpackage

`default_nettype wire

/* design/ppu_line_pkg.sv */
`default_nettype none

package ppu_line_pkg;

    localparam int OAM_WORDS  = 80;   // 40 entries, two words each
    localparam int SLOT_COUNT = 10;   // Sprites per line
    localparam int LINE_WIDTH = 160;

    // OAM coordinates are stored with these offsets added
    localparam int OBJ_Y_OFFSET = 16;
    localparam int OBJ_X_OFFSET = 8;

endpackage

`default_nettype wire

/* design/oam_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module oam_scan (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      line_start,
    input  logic [7:0]                ly,
    input  logic                      tall,
    input  logic [15:0]               oam_d,
    output logic [6:0]                oam_addr,
    output logic                      load,
    output logic [7:0]                load_x,
    output ppu_obj_pkg::sprite_data_t load_data,
    output logic                      load_skip,
    output logic                      scan_done
);
    import ppu_obj_pkg::*;
    import ppu_line_pkg::*;

    logic       busy;
    logic [7:0] line_q;
    logic       tall_q;
    logic [15:0] even_q;     // y and x of the entry being assembled
    oam_entry_t entry;
    logic [7:0] row;
    logic [3:0] row_f;
    logic       visible;

    assign entry = {even_q, oam_d};

    // Row relative to the sprite top, wraps to large values above it
    assign row = line_q - (entry.y - 8'(OBJ_Y_OFFSET));
    assign visible = tall_q ? (row[7:4] == 4'd0) : (row[7:3] == 5'd0);
    assign row_f = entry.attrs[4 + ATTR_VFLIP] ? ~row[3:0] : row[3:0];

    assign load = busy;
    assign load_skip = ~oam_addr[0] | ~visible;   // Only odd words carry a whole entry
    assign load_x = entry.x - 8'(OBJ_X_OFFSET);
    assign load_data.row = row_f[2:0];
    assign load_data.tile = tall_q ? {entry.tile[7:1], row_f[3]} : entry.tile;
    assign load_data.attrs = entry.attrs[7:4];
    assign scan_done = busy && (oam_addr == 7'(OAM_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            oam_addr <= '0;
        end else if (busy) begin
            if (scan_done) begin
                busy <= 1'b0;
                oam_addr <= '0;
            end else begin
                oam_addr <= oam_addr + 7'd1;
            end
        end else if (line_start) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_start && !busy) begin
            line_q <= ly;
            tall_q <= tall;
        end
        if (busy && !oam_addr[0]) even_q <= oam_d;
    end

    a_addr_range: assert property (@(posedge clk) disable iff (!rst)
        load |-> oam_addr <= 7'(OAM_WORDS - 1));

endmodule

`default_nettype wire

/* design/sprite_slot.sv */
`timescale 1ns/10ps
`default_nettype none

module sprite_slot (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic [7:0]                prev_x,
    input  ppu_obj_pkg::sprite_data_t prev_data,
    input  logic                      prev_bypass,
    output logic [7:0]                next_x,
    output ppu_obj_pkg::sprite_data_t next_data,
    output logic                      next_bypass
);
    import ppu_obj_pkg::*;

    logic         ready;     // Holds a sprite not yet handed out
    logic         load_q;
    logic [7:0]   x_q;
    sprite_data_t data_q;
    logic         fresh;
    logic         full;
    logic         take;
    logic         answer;

    // A new scan starts with every slot empty
    assign fresh = load & ~load_q;
    assign full = ready & ~fresh;

    assign take = load & ~full & ~prev_bypass;     // First free slot
    assign answer = ~load & full & ~prev_bypass & (x_q == prev_x);

    assign next_x = prev_x;
    assign next_data = (take | answer) ? data_q : prev_data;
    assign next_bypass = prev_bypass | take | answer;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready <= 1'b0;
            load_q <= 1'b0;
        end else begin
            load_q <= load;
            if (take) ready <= 1'b1;
            else if (answer || fresh) ready <= 1'b0;   // Gives later slots their turn
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            x_q <= prev_x;
            data_q <= prev_data;
        end
    end

endmodule

`default_nettype wire

/* design/sprite_store.sv */
`timescale 1ns/10ps
`default_nettype none

module sprite_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic [7:0]                load_x,
    input  ppu_obj_pkg::sprite_data_t load_data,
    input  logic                      load_skip,
    input  logic                      query,
    input  logic [7:0]                query_x,
    output logic                      hit,
    output ppu_obj_pkg::sprite_data_t hit_data
);
    import ppu_obj_pkg::*;
    import ppu_line_pkg::*;

    logic [7:0]          chain_x [0:SLOT_COUNT];
    sprite_data_t        chain_data [0:SLOT_COUNT];
    logic [SLOT_COUNT:0] chain_bypass;

    // Head of the chain carries either an OAM entry or an x lookup
    assign chain_x[0] = load ? load_x : query_x;
    assign chain_data[0] = load ? load_data : '0;
    assign chain_bypass[0] = load ? load_skip : ~query;   // Idle chain is bypassed

    for (genvar i = 0; i < SLOT_COUNT; i++) begin : g_slot
        sprite_slot u_slot (
            .clk        (clk),
            .rst        (rst),
            .load       (load),
            .prev_x     (chain_x[i]),
            .prev_data  (chain_data[i]),
            .prev_bypass(chain_bypass[i]),
            .next_x     (chain_x[i + 1]),
            .next_data  (chain_data[i + 1]),
            .next_bypass(chain_bypass[i + 1])
        );
    end

    // Some slot answered the query
    assign hit = query & ~load & chain_bypass[SLOT_COUNT];
    assign hit_data = chain_data[SLOT_COUNT];

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst)
        !(load && query));

endmodule

`default_nettype wire

/* design/obj_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      scan_done,
    input  logic                      hit,
    input  ppu_obj_pkg::sprite_data_t hit_data,
    input  logic [7:0]                vram_d,
    output logic                      query,
    output logic [7:0]                query_x,
    output logic [12:0]               vram_addr,
    output logic                      merge,
    output logic [7:0]                plane_lo,
    output logic [7:0]                plane_hi,
    output logic [3:0]                merge_attrs,
    output logic                      pop,
    output logic                      line_done
);
    import ppu_obj_pkg::*;
    import ppu_line_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_QUERY,
        ST_READ_LO,
        ST_READ_HI,
        ST_MERGE
    } fetch_state_t;

    fetch_state_t state;
    logic [7:0]   x_q;        // Parked at LINE_WIDTH between lines
    sprite_data_t sprite_q;
    logic [7:0]   lo_q;
    logic [7:0]   hi_q;

    assign query = (state == ST_QUERY);
    assign query_x = x_q;
    assign pop = query & ~hit;
    assign merge = (state == ST_MERGE);

    // tile * 16 + row * 2 + plane
    assign vram_addr = {1'b0, sprite_q.tile, sprite_q.row, state == ST_READ_HI};

    assign plane_lo = lo_q;
    assign plane_hi = hi_q;
    assign merge_attrs = sprite_q.attrs;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_IDLE;
            x_q <= 8'(LINE_WIDTH);
            line_done <= 1'b0;
        end else begin
            // Lines up with pix_valid of the last pixel
            line_done <= pop && (x_q == 8'(LINE_WIDTH - 1));
            case (state)
                ST_IDLE: begin
                    if (scan_done) begin
                        state <= ST_QUERY;
                        x_q <= '0;
                    end
                end
                ST_QUERY: begin
                    if (hit) begin
                        state <= ST_READ_LO;
                    end else begin
                        x_q <= x_q + 8'd1;
                        if (x_q == 8'(LINE_WIDTH - 1)) state <= ST_IDLE;
                    end
                end
                ST_READ_LO: state <= ST_READ_HI;
                ST_READ_HI: state <= ST_MERGE;
                ST_MERGE:   state <= ST_QUERY;      // Same x again for the next sprite
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_QUERY && hit) sprite_q <= hit_data;
        if (state == ST_READ_LO) lo_q <= vram_d;
        if (state == ST_READ_HI) hi_q <= vram_d;
    end

    a_pop_merge: assert property (@(posedge clk) disable iff (!rst)
        !(pop && merge));

endmodule

`default_nettype wire

/* design/obj_mixer.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_mixer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    merge,
    input  logic [7:0]              plane_lo,
    input  logic [7:0]              plane_hi,
    input  logic [3:0]              merge_attrs,
    input  logic                    pop,
    output ppu_obj_pkg::obj_pixel_t pix,
    output logic                    pix_valid
);
    import ppu_obj_pkg::*;
    import ppu_line_pkg::*;

    obj_pixel_t lane_q [0:7];    // Lane 0 is the pixel at the current x
    obj_pixel_t new_pix [0:7];
    logic [7:0] pop_cnt;
    logic       last_pop;

    // Plane bit 7 is the leftmost pixel unless flipped
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (merge_attrs[ATTR_HFLIP]) begin
                new_pix[i].color = {plane_hi[i], plane_lo[i]};
            end else begin
                new_pix[i].color = {plane_hi[7 - i], plane_lo[7 - i]};
            end
            new_pix[i].pal = merge_attrs[ATTR_PAL];
            new_pix[i].prio = merge_attrs[ATTR_PRIO];
        end
    end

    assign last_pop = (pop_cnt == 8'(LINE_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 8; i++) lane_q[i] <= '0;
            pop_cnt <= '0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= pop;
            if (merge) begin
                // Earlier sprites keep their opaque pixels
                for (int i = 0; i < 8; i++) begin
                    if (lane_q[i].color == 2'b00 && new_pix[i].color != 2'b00) begin
                        lane_q[i] <= new_pix[i];
                    end
                end
            end else if (pop) begin
                if (last_pop) begin
                    // Drop anything hanging past the right edge
                    for (int i = 0; i < 8; i++) lane_q[i] <= '0;
                    pop_cnt <= '0;
                end else begin
                    for (int i = 0; i < 7; i++) lane_q[i] <= lane_q[i + 1];
                    lane_q[7] <= '0;
                    pop_cnt <= pop_cnt + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) pix <= lane_q[0];
    end

endmodule

`default_nettype wire

/* design/obj_line_top.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_line_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_start,
    input  logic [7:0]              ly,
    input  logic                    tall,
    input  logic [15:0]             oam_d,
    input  logic [7:0]              vram_d,
    output logic [6:0]              oam_addr,
    output logic [12:0]             vram_addr,
    output ppu_obj_pkg::obj_pixel_t pix,
    output logic                    pix_valid,
    output logic                    line_done
);
    import ppu_obj_pkg::*;
    import ppu_line_pkg::*;

    logic         scan_start;
    logic         load;
    logic [7:0]   load_x;
    sprite_data_t load_data;
    logic         load_skip;
    logic         scan_done;
    logic         query;
    logic [7:0]   query_x;
    logic         hit;
    sprite_data_t hit_data;
    logic         merge;
    logic [7:0]   plane_lo;
    logic [7:0]   plane_hi;
    logic [3:0]   merge_attrs;
    logic         pop;

    // Fetcher parks x past the last pixel when it is idle
    assign scan_start = line_start & (query_x == 8'(LINE_WIDTH));

    oam_scan u_scan (
        .clk(clk), .rst(rst), .line_start(scan_start), .ly(ly), .tall(tall),
        .oam_d(oam_d), .oam_addr(oam_addr), .load(load), .load_x(load_x),
        .load_data(load_data), .load_skip(load_skip), .scan_done(scan_done)
    );

    sprite_store u_store (
        .clk(clk), .rst(rst), .load(load), .load_x(load_x), .load_data(load_data),
        .load_skip(load_skip), .query(query), .query_x(query_x),
        .hit(hit), .hit_data(hit_data)
    );

    obj_fetch u_fetch (
        .clk(clk), .rst(rst), .scan_done(scan_done), .hit(hit), .hit_data(hit_data),
        .vram_d(vram_d), .query(query), .query_x(query_x), .vram_addr(vram_addr),
        .merge(merge), .plane_lo(plane_lo), .plane_hi(plane_hi),
        .merge_attrs(merge_attrs), .pop(pop), .line_done(line_done)
    );

    obj_mixer u_mixer (
        .clk(clk), .rst(rst), .merge(merge), .plane_lo(plane_lo), .plane_hi(plane_hi),
        .merge_attrs(merge_attrs), .pop(pop), .pix(pix), .pix_valid(pix_valid)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    localparam int PERIOD = 100;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Active low, released just after an edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/obj_line_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_line_tb;
    import ppu_obj_pkg::*;
    import ppu_line_pkg::*;

    localparam int DRIVE_DELAY = 1;
    localparam int RANDOM_LINES = 6;
    localparam int LINE_COUNT = 6 + RANDOM_LINES;      // Directed lines plus random ones
    localparam int CYCLE_LIMIT = 400 * LINE_COUNT + 10;
    localparam logic [31:0] SEED = 32'h02fb6f82;

    logic        clk;
    logic        rst;
    logic        line_start;
    logic [7:0]  ly;
    logic        tall;
    logic [15:0] oam_d;
    logic [7:0]  vram_d;
    logic [6:0]  oam_addr;
    logic [12:0] vram_addr;
    obj_pixel_t  pix;
    logic        pix_valid;
    logic        line_done;

    logic [15:0] oam_mem [0:OAM_WORDS - 1];
    logic [7:0]  vram_mem [0:8191];
    obj_pixel_t  ref_line [0:LINE_WIDTH - 1];
    logic [31:0] rng;
    int          cycle_count = 0;

    tb_clock u_clock (.clk(clk), .rst(rst));

    obj_line_top DUT (
        .clk(clk), .rst(rst), .line_start(line_start), .ly(ly), .tall(tall),
        .oam_d(oam_d), .vram_d(vram_d), .oam_addr(oam_addr), .vram_addr(vram_addr),
        .pix(pix), .pix_valid(pix_valid), .line_done(line_done)
    );

    // Both memories answer in the same cycle
    assign oam_d = oam_mem[oam_addr];
    assign vram_d = vram_mem[vram_addr];

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout: run still busy after %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic check_pixel(input int idx, input obj_pixel_t got, input obj_pixel_t want);
        if (got !== want) begin
            abort_run($sformatf("Error at %0t ns: pix[%0d] = %h, expected %h",
                                $time, idx, got, want));
        end
    endtask

    task automatic check_count(input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("Error at %0t ns: pixel count = %0d, expected %0d",
                                $time, got, want));
        end
    endtask

    task automatic clear_oam();
        for (int k = 0; k < OAM_WORDS; k++) oam_mem[k] = '0;   // y = 0 is never on screen
    endtask

    task automatic fill_vram();
        for (int a = 0; a < 8192; a++) vram_mem[a] = 8'(a * 13) ^ 8'(a >> 8);
    endtask

    task automatic set_sprite(input int idx, input logic [7:0] y, input logic [7:0] x,
                              input logic [7:0] tile, input logic [7:0] attrs);
        oam_mem[2 * idx] = {y, x};
        oam_mem[2 * idx + 1] = {tile, attrs};
    endtask

    task automatic set_tile_row(input logic [7:0] tile, input int row,
                                input logic [7:0] lo, input logic [7:0] hi);
        vram_mem[int'(tile) * 16 + row * 2] = lo;
        vram_mem[int'(tile) * 16 + row * 2 + 1] = hi;
    endtask

    // Draws one OAM entry into the reference line where it is still transparent
    task automatic paint_sprite(input int k, input logic [7:0] line, input logic tall_v);
        logic [7:0] y;
        logic [7:0] x;
        logic [7:0] tile;
        logic [7:0] attrs;
        logic [7:0] row;
        logic [7:0] lo;
        logic [7:0] hi;
        int         base;
        int         sx;
        int         b;
        obj_pixel_t p;
        {y, x} = oam_mem[2 * k];
        {tile, attrs} = oam_mem[2 * k + 1];
        row = 8'(int'(line) + OBJ_Y_OFFSET - int'(y));
        if (attrs[4 + ATTR_VFLIP]) row = 8'((tall_v ? 15 : 7) - int'(row));
        if (tall_v) tile = {tile[7:1], row[3]};            // Lower half is the odd tile
        base = int'(tile) * 16 + int'(row[2:0]) * 2;
        lo = vram_mem[base];
        hi = vram_mem[base + 1];
        for (int c = 0; c < 8; c++) begin
            b = attrs[4 + ATTR_HFLIP] ? c : 7 - c;          // Bit 7 is leftmost
            p.color = {hi[b], lo[b]};
            p.pal = attrs[4 + ATTR_PAL];
            p.prio = attrs[4 + ATTR_PRIO];
            sx = int'(x) - OBJ_X_OFFSET + c;
            if (sx < LINE_WIDTH && p.color != 2'b00 && ref_line[sx].color == 2'b00) begin
                ref_line[sx] = p;
            end
        end
    endtask

    task automatic build_reference(input logic [7:0] line, input logic tall_v);
        int         sel [$];
        logic [7:0] row;
        int         height;
        height = tall_v ? 16 : 8;
        for (int i = 0; i < LINE_WIDTH; i++) ref_line[i] = '0;
        // First ten entries on the line, whatever their x
        for (int k = 0; k < OAM_WORDS / 2; k++) begin
            row = 8'(int'(line) + OBJ_Y_OFFSET - int'(oam_mem[2 * k][15:8]));
            if (int'(row) < height && sel.size() < SLOT_COUNT) sel.push_back(k);
        end
        // Smaller x is drawn first, OAM order among equal x
        for (int xv = OBJ_X_OFFSET; xv < LINE_WIDTH + OBJ_X_OFFSET; xv++) begin
            foreach (sel[j]) begin
                if (int'(oam_mem[2 * sel[j]][7:0]) == xv) paint_sprite(sel[j], line, tall_v);
            end
        end
    endtask

    task automatic run_line(input logic [7:0] line, input logic tall_v);
        int   got_count;
        logic done;
        build_reference(line, tall_v);
        @(posedge clk);
        #DRIVE_DELAY;
        line_start = 1'b1;
        ly = line;
        tall = tall_v;
        @(posedge clk);
        #DRIVE_DELAY;
        line_start = 1'b0;
        got_count = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);                                 // Outputs settled mid cycle
            if (pix_valid) begin
                if (got_count >= LINE_WIDTH) check_count(got_count + 1, LINE_WIDTH);
                check_pixel(got_count, pix, ref_line[got_count]);
                got_count++;
            end
            if (line_done) begin
                check_count(got_count, LINE_WIDTH);
                done = 1'b1;
            end
        end
    endtask

    task automatic single_sprite_line();
        clear_oam();
        set_sprite(0, 8'd33, 8'd48, 8'h05, 8'h00);         // Row 3 on line 20, screen x 40
        set_tile_row(8'h05, 3, 8'ha5, 8'h3c);
        run_line(8'd20, 1'b0);
    endtask

    task automatic tall_and_vflip_lines();
        clear_oam();
        set_sprite(0, 8'd55, 8'd38, 8'h20, 8'h00);         // Row 11
        set_sprite(1, 8'd64, 8'd90, 8'h30, 8'h40);         // Row 2, flipped to 13
        set_tile_row(8'h20, 3, 8'hff, 8'hff);
        set_tile_row(8'h21, 3, 8'hc3, 8'h81);
        set_tile_row(8'h30, 2, 8'h55, 8'h55);
        set_tile_row(8'h31, 5, 8'h0f, 8'hf0);
        run_line(8'd50, 1'b1);
        clear_oam();
        set_sprite(0, 8'd75, 8'd70, 8'h40, 8'h40);         // Row 1 reads row 6
        set_tile_row(8'h40, 1, 8'he7, 8'h00);
        set_tile_row(8'h40, 6, 8'h18, 8'h7e);
        run_line(8'd60, 1'b0);
    endtask

    task automatic hflip_attr_line();
        clear_oam();
        set_sprite(0, 8'd102, 8'd108, 8'h50, 8'hb0);
        set_sprite(1, 8'd102, 8'd128, 8'h50, 8'h90);       // Same tile, not flipped
        set_tile_row(8'h50, 4, 8'he1, 8'h96);
        run_line(8'd90, 1'b0);
    endtask

    task automatic overlap_line();
        clear_oam();
        set_sprite(0, 8'd46, 8'd68, 8'h60, 8'h00);         // Left half opaque
        set_sprite(1, 8'd46, 8'd68, 8'h61, 8'h10);
        set_sprite(2, 8'd46, 8'd72, 8'h61, 8'h80);
        set_tile_row(8'h60, 0, 8'hf0, 8'h00);
        set_tile_row(8'h61, 0, 8'hff, 8'hff);
        run_line(8'd30, 1'b0);
    endtask

    task automatic sprite_limit_line();
        clear_oam();
        set_sprite(0, 8'd200, 8'd40, 8'h70, 8'h00);        // Off the line
        set_sprite(1, 8'd111, 8'd4, 8'h71, 8'h00);         // Takes a slot, never drawn
        for (int i = 2; i < 14; i++) begin
            set_sprite(i, 8'(111 + i % 3), 8'(16 + 12 * (i - 2)), 8'(8'h70 + i), 8'h00);
        end
        run_line(8'd100, 1'b0);
    endtask

    task automatic random_lines();
        logic [7:0] line;
        logic       tall_v;
        for (int a = 0; a < 8192; a++) begin
            rng = xorshift32(rng);
            vram_mem[a] = rng[7:0];
        end
        for (int n = 0; n < RANDOM_LINES; n++) begin
            rng = xorshift32(rng);
            line = 8'(rng % 144);
            tall_v = rng[31];
            for (int k = 0; k < OAM_WORDS / 2; k++) begin
                rng = xorshift32(rng);
                set_sprite(k, 8'(int'(line) + OBJ_Y_OFFSET - int'(rng[4:0])),
                           8'(rng[12:5] % 8'd176), rng[20:13], {rng[24:21], 4'h0});
            end
            run_line(line, tall_v);
        end
    endtask

    initial begin
        line_start = 1'b0;
        ly = '0;
        tall = 1'b0;
        rng = SEED;
        clear_oam();
        fill_vram();
        @(posedge rst);
        single_sprite_line();
        tall_and_vflip_lines();
        hflip_attr_line();
        overlap_line();
        sprite_limit_line();
        random_lines();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/ppu_obj_pkg.sv
design/ppu_line_pkg.sv
design/oam_scan.sv
design/sprite_slot.sv
design/sprite_store.sv
design/obj_fetch.sv
design/obj_mixer.sv
design/obj_line_top.sv
tb/tb_clock.sv
tb/obj_line_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the object line testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module obj_line_tb -o obj_line_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/obj_line_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
else
    echo "Pass line not found in sim.log"
    exit 1
fi
